// ==== include/rv_backend_defines.svh ====
`ifndef RV_BACKEND_DEFINES_SVH
`define RV_BACKEND_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// register file address width
`define RV_REG_AW 5

// data RAM depth in words
`define RV_DMEM_WORDS 256

`endif

// ==== hw/rv_backend_pkg.sv ====
`default_nettype none

package rv_backend_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // operand b straight through, used by lui
        PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } br_op_e;

    // loads first so that a bubble decodes as LB
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        DEST_ALU = 2'd0,
        DEST_MEM,
        DEST_PC4
    } data_dest_e;

endpackage

`default_nettype wire

// ==== hw/ex_mem_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_backend_defines.svh"

interface ex_mem_if;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] new_pc;
    logic br_sig;
    logic br_taken;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] rs2;
    rv_backend_pkg::data_dest_e data_dest;
    rv_backend_pkg::lsu_op_e lsu_op;
    logic [`RV_REG_AW-1:0] reg_wr_addr;
    logic reg_wr_sig;
    logic mem_wr_sig;
    logic br_pred;
    logic [`RV_XLEN-1:0] new_pc_pred;

    modport producer (
        output pc, new_pc, br_sig, br_taken, pc_plus4,
        output alu_result, rs2, data_dest,
        output lsu_op, reg_wr_addr, reg_wr_sig, mem_wr_sig,
        output br_pred, new_pc_pred
    );

    modport consumer (
        input pc, new_pc, br_sig, br_taken, pc_plus4,
        input alu_result, rs2, data_dest,
        input lsu_op, reg_wr_addr, reg_wr_sig, mem_wr_sig,
        input br_pred, new_pc_pred
    );

endinterface

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_backend_defines.svh"

module execute_stage (
    input wire [`RV_XLEN-1:0] pc_i,
    input wire [`RV_XLEN-1:0] rs1_i,
    input wire [`RV_XLEN-1:0] rs2_i,
    input wire [`RV_XLEN-1:0] imm_i,
    input wire rv_backend_pkg::alu_op_e alu_op_i,
    input wire alu_src_imm_i,
    input wire br_sig_i,
    input wire rv_backend_pkg::br_op_e br_op_i,
    input wire br_pred_i,
    input wire [`RV_XLEN-1:0] new_pc_pred_i,
    input wire rv_backend_pkg::data_dest_e data_dest_i,
    input wire rv_backend_pkg::lsu_op_e lsu_op_i,
    input wire [`RV_REG_AW-1:0] reg_wr_addr_i,
    input wire reg_wr_sig_i,
    input wire mem_wr_sig_i,

    ex_mem_if.producer ex_o
);

    localparam int SHW = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op_b;
    logic [SHW-1:0] shamt;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] jalr_target;
    logic br_cond;

    assign op_b = alu_src_imm_i ? imm_i : rs2_i;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (alu_op_i)
            rv_backend_pkg::ADD:    alu_result = rs1_i + op_b;
            rv_backend_pkg::SUB:    alu_result = rs1_i - op_b;
            rv_backend_pkg::AND:    alu_result = rs1_i & op_b;
            rv_backend_pkg::OR:     alu_result = rs1_i | op_b;
            rv_backend_pkg::XOR:    alu_result = rs1_i ^ op_b;
            rv_backend_pkg::SLL:    alu_result = rs1_i << shamt;
            rv_backend_pkg::SRL:    alu_result = rs1_i >> shamt;
            rv_backend_pkg::SRA:    alu_result = $signed(rs1_i) >>> shamt;
            rv_backend_pkg::SLT: begin
                alu_result = {{(`RV_XLEN-1){1'b0}}, ($signed(rs1_i) < $signed(op_b))};
            end
            rv_backend_pkg::SLTU: begin
                alu_result = {{(`RV_XLEN-1){1'b0}}, (rs1_i < op_b)};
            end
            rv_backend_pkg::PASS_B: alu_result = op_b;
            default:                alu_result = rs1_i + op_b;
        endcase
    end

    // branch comparator always works on the two registers
    always_comb begin
        case (br_op_i)
            rv_backend_pkg::BEQ:  br_cond = (rs1_i == rs2_i);
            rv_backend_pkg::BNE:  br_cond = (rs1_i != rs2_i);
            rv_backend_pkg::BLT:  br_cond = ($signed(rs1_i) < $signed(rs2_i));
            rv_backend_pkg::BGE:  br_cond = ($signed(rs1_i) >= $signed(rs2_i));
            rv_backend_pkg::BLTU: br_cond = (rs1_i < rs2_i);
            rv_backend_pkg::BGEU: br_cond = (rs1_i >= rs2_i);
            rv_backend_pkg::JAL,
            rv_backend_pkg::JALR: br_cond = 1'b1;
            default:              br_cond = 1'b0;
        endcase
    end

    assign jalr_target = (rs1_i + imm_i) & ~{{(`RV_XLEN-1){1'b0}}, 1'b1};

    assign ex_o.pc          = pc_i;
    assign ex_o.new_pc      = (br_op_i == rv_backend_pkg::JALR) ? jalr_target : pc_i + imm_i;
    assign ex_o.br_sig      = br_sig_i;
    // only meaningful for control flow instructions
    assign ex_o.br_taken    = br_sig_i & br_cond;
    assign ex_o.pc_plus4    = pc_i + `RV_XLEN'd4;
    assign ex_o.alu_result  = alu_result;
    assign ex_o.rs2         = rs2_i;
    assign ex_o.data_dest   = data_dest_i;
    assign ex_o.lsu_op      = lsu_op_i;
    assign ex_o.reg_wr_addr = reg_wr_addr_i;
    assign ex_o.reg_wr_sig  = reg_wr_sig_i;
    assign ex_o.mem_wr_sig  = mem_wr_sig_i;
    assign ex_o.br_pred     = br_pred_i;
    assign ex_o.new_pc_pred = new_pc_pred_i;

endmodule

`default_nettype wire

// ==== hw/ex_mem_register.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_mem_register (
    input wire clk,
    input wire reset_n,
    input wire flush_i,

    ex_mem_if.consumer ex_i,
    ex_mem_if.producer mem_o
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_o.pc          <= '0;
            mem_o.new_pc      <= '0;
            mem_o.br_sig      <= 1'b0;
            mem_o.br_taken    <= 1'b0;
            mem_o.pc_plus4    <= '0;
            mem_o.alu_result  <= '0;
            mem_o.rs2         <= '0;
            mem_o.data_dest   <= rv_backend_pkg::DEST_ALU;
            mem_o.lsu_op      <= rv_backend_pkg::LB;
            mem_o.reg_wr_addr <= '0;
            mem_o.reg_wr_sig  <= 1'b0;
            mem_o.mem_wr_sig  <= 1'b0;
            mem_o.br_pred     <= 1'b0;
            mem_o.new_pc_pred <= '0;
        end else if (flush_i) begin
            // insert a bubble
            mem_o.pc          <= '0;
            mem_o.new_pc      <= '0;
            mem_o.br_sig      <= 1'b0;
            mem_o.br_taken    <= 1'b0;
            mem_o.pc_plus4    <= '0;
            mem_o.alu_result  <= '0;
            mem_o.rs2         <= '0;
            mem_o.data_dest   <= rv_backend_pkg::DEST_ALU;
            mem_o.lsu_op      <= rv_backend_pkg::LB;
            mem_o.reg_wr_addr <= '0;
            mem_o.reg_wr_sig  <= 1'b0;
            mem_o.mem_wr_sig  <= 1'b0;
            mem_o.br_pred     <= 1'b0;
            mem_o.new_pc_pred <= '0;
        end else begin
            mem_o.pc          <= ex_i.pc;
            mem_o.new_pc      <= ex_i.new_pc;
            mem_o.br_sig      <= ex_i.br_sig;
            mem_o.br_taken    <= ex_i.br_taken;
            mem_o.pc_plus4    <= ex_i.pc_plus4;
            mem_o.alu_result  <= ex_i.alu_result;
            mem_o.rs2         <= ex_i.rs2;
            mem_o.data_dest   <= ex_i.data_dest;
            mem_o.lsu_op      <= ex_i.lsu_op;
            mem_o.reg_wr_addr <= ex_i.reg_wr_addr;
            mem_o.reg_wr_sig  <= ex_i.reg_wr_sig;
            mem_o.mem_wr_sig  <= ex_i.mem_wr_sig;
            mem_o.br_pred     <= ex_i.br_pred;
            mem_o.new_pc_pred <= ex_i.new_pc_pred;
        end
    end

    // a flushed slot must not write the register file or memory downstream
    flush_gives_bubble_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        flush_i |=> (!mem_o.reg_wr_sig && !mem_o.mem_wr_sig)
    ) else $error("ex_mem_register: side effects survived a flush");

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_backend_defines.svh"

module memory_stage (
    input wire clk,
    input wire reset_n,

    ex_mem_if.consumer mem_i,

    output logic redirect_o,
    output logic [`RV_XLEN-1:0] redirect_pc_o,
    output logic wb_valid_o,
    output logic [`RV_REG_AW-1:0] wb_addr_o,
    output logic [`RV_XLEN-1:0] wb_data_o
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);
    localparam int NB = `RV_XLEN / 8;

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];

    logic [DMEM_AW-1:0] word_idx;
    logic [1:0] byte_off;
    logic [NB-1:0] byte_en;
    logic [`RV_XLEN-1:0] store_data;
    logic [`RV_XLEN-1:0] load_word;
    logic [`RV_XLEN-1:0] load_shift;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] actual_pc;
    logic [`RV_XLEN-1:0] pred_pc;

    assign word_idx = mem_i.alu_result[DMEM_AW+1:2];
    assign byte_off = mem_i.alu_result[1:0];

    // store lanes
    always_comb begin
        case (mem_i.lsu_op)
            rv_backend_pkg::SB: byte_en = {{(NB-1){1'b0}}, 1'b1} << byte_off;
            rv_backend_pkg::SH: byte_en = {{(NB-2){1'b0}}, 2'b11} << byte_off;
            rv_backend_pkg::SW: byte_en = '1;
            default:            byte_en = '0;
        endcase
    end

    assign store_data = mem_i.rs2 << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (mem_i.mem_wr_sig) begin
            for (int i = 0; i < NB; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][8*i +: 8] <= store_data[8*i +: 8];
                end
            end
        end
    end

    // load path, asynchronous read
    assign load_word = dmem[word_idx];
    assign load_shift = load_word >> {byte_off, 3'b000};

    always_comb begin
        case (mem_i.lsu_op)
            rv_backend_pkg::LB: begin
                load_data = {{(`RV_XLEN-8){load_shift[7]}}, load_shift[7:0]};
            end
            rv_backend_pkg::LH: begin
                load_data = {{(`RV_XLEN-16){load_shift[15]}}, load_shift[15:0]};
            end
            rv_backend_pkg::LBU: load_data = {{(`RV_XLEN-8){1'b0}}, load_shift[7:0]};
            rv_backend_pkg::LHU: load_data = {{(`RV_XLEN-16){1'b0}}, load_shift[15:0]};
            default:             load_data = load_word;
        endcase
    end

    // prediction check
    assign actual_pc = mem_i.br_taken ? mem_i.new_pc : mem_i.pc_plus4;
    assign pred_pc = mem_i.br_pred ? mem_i.new_pc_pred : mem_i.pc_plus4;
    assign redirect_o = mem_i.br_sig && (actual_pc != pred_pc);
    assign redirect_pc_o = actual_pc;

    // MEM/WB register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid_o <= 1'b0;
            wb_addr_o  <= '0;
            wb_data_o  <= '0;
        end else begin
            // x0 is never written
            wb_valid_o <= mem_i.reg_wr_sig && (mem_i.reg_wr_addr != '0);
            wb_addr_o  <= mem_i.reg_wr_addr;
            case (mem_i.data_dest)
                rv_backend_pkg::DEST_MEM: wb_data_o <= load_data;
                rv_backend_pkg::DEST_PC4: wb_data_o <= mem_i.pc_plus4;
                default:                  wb_data_o <= mem_i.alu_result;
            endcase
        end
    end

    store_aligned_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_i.mem_wr_sig |->
            !((mem_i.lsu_op == rv_backend_pkg::SH && byte_off[0]) ||
              (mem_i.lsu_op == rv_backend_pkg::SW && byte_off != 2'b00))
    ) else $error("memory_stage: misaligned store at pc %h", mem_i.pc);

endmodule

`default_nettype wire

// ==== hw/rv_backend_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_backend_defines.svh"

module rv_backend_top (
    input wire clk,
    input wire reset_n,
    input wire flush_i,

    input wire [`RV_XLEN-1:0] pc_i,
    input wire [`RV_XLEN-1:0] rs1_i,
    input wire [`RV_XLEN-1:0] rs2_i,
    input wire [`RV_XLEN-1:0] imm_i,
    input wire rv_backend_pkg::alu_op_e alu_op_i,
    input wire alu_src_imm_i,
    input wire br_sig_i,
    input wire rv_backend_pkg::br_op_e br_op_i,
    input wire br_pred_i,
    input wire [`RV_XLEN-1:0] new_pc_pred_i,
    input wire rv_backend_pkg::data_dest_e data_dest_i,
    input wire rv_backend_pkg::lsu_op_e lsu_op_i,
    input wire [`RV_REG_AW-1:0] reg_wr_addr_i,
    input wire reg_wr_sig_i,
    input wire mem_wr_sig_i,

    output logic redirect_o,
    output logic [`RV_XLEN-1:0] redirect_pc_o,
    output logic wb_valid_o,
    output logic [`RV_REG_AW-1:0] wb_addr_o,
    output logic [`RV_XLEN-1:0] wb_data_o
);

    ex_mem_if ex_to_reg ();
    ex_mem_if reg_to_mem ();

    execute_stage i_execute_stage (
        .pc_i          (pc_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .alu_op_i      (alu_op_i),
        .alu_src_imm_i (alu_src_imm_i),
        .br_sig_i      (br_sig_i),
        .br_op_i       (br_op_i),
        .br_pred_i     (br_pred_i),
        .new_pc_pred_i (new_pc_pred_i),
        .data_dest_i   (data_dest_i),
        .lsu_op_i      (lsu_op_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_sig_i  (reg_wr_sig_i),
        .mem_wr_sig_i  (mem_wr_sig_i),
        .ex_o          (ex_to_reg.producer)
    );

    ex_mem_register i_ex_mem_register (
        .clk     (clk),
        .reset_n (reset_n),
        .flush_i (flush_i),
        .ex_i    (ex_to_reg.consumer),
        .mem_o   (reg_to_mem.producer)
    );

    memory_stage i_memory_stage (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_i         (reg_to_mem.consumer),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rv_backend.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_backend_defines.svh"

module tb_rv_backend;

    localparam int MAX_CYCLES = 2000;
    localparam int DMEM_BYTES = 4 * `RV_DMEM_WORDS;

    typedef struct {
        string name;
        logic [`RV_XLEN-1:0] pc, rs1, rs2, imm, pred_pc;
        rv_backend_pkg::alu_op_e alu_op;
        rv_backend_pkg::br_op_e br_op;
        rv_backend_pkg::data_dest_e dest;
        rv_backend_pkg::lsu_op_e lsu_op;
        logic src_imm, br_sig, br_pred, reg_wr, mem_wr, flush;
        logic [`RV_REG_AW-1:0] rd;
        logic exp_wb_valid;
        logic exp_redirect;
        logic [`RV_XLEN-1:0] exp_wb_data;
        logic [`RV_XLEN-1:0] exp_redirect_pc;
    } row_t;

    logic clk;
    logic reset_n;
    logic flush_i;
    logic [`RV_XLEN-1:0] pc_i, rs1_i, rs2_i, imm_i, new_pc_pred_i;
    rv_backend_pkg::alu_op_e alu_op_i;
    rv_backend_pkg::br_op_e br_op_i;
    rv_backend_pkg::data_dest_e data_dest_i;
    rv_backend_pkg::lsu_op_e lsu_op_i;
    logic alu_src_imm_i, br_sig_i, br_pred_i, reg_wr_sig_i, mem_wr_sig_i;
    logic [`RV_REG_AW-1:0] reg_wr_addr_i;
    logic redirect_o;
    logic [`RV_XLEN-1:0] redirect_pc_o;
    logic wb_valid_o;
    logic [`RV_REG_AW-1:0] wb_addr_o;
    logic [`RV_XLEN-1:0] wb_data_o;

    row_t rows[$];
    // byte image of the data RAM as the program should leave it
    logic [7:0] shadow [DMEM_BYTES];
    integer seed;

    rv_backend_top i_rv_backend_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
    end

    // watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    function automatic logic signed_less(input logic [`RV_XLEN-1:0] a,
                                         input logic [`RV_XLEN-1:0] b);
        if (a[`RV_XLEN-1] != b[`RV_XLEN-1])
            return a[`RV_XLEN-1];
        return a < b;
    endfunction

    function automatic logic [`RV_XLEN-1:0] alu_ref(input rv_backend_pkg::alu_op_e op,
            input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
        logic [4:0] sh;
        logic [`RV_XLEN-1:0] r;
        sh = b[4:0];
        case (op)
            rv_backend_pkg::ADD:  r = a + b;
            rv_backend_pkg::SUB:  r = a + ~b + 1;
            rv_backend_pkg::AND:  r = a & b;
            rv_backend_pkg::OR:   r = a | b;
            rv_backend_pkg::XOR:  r = a ^ b;
            rv_backend_pkg::SLL:  r = a << sh;
            rv_backend_pkg::SRL:  r = a >> sh;
            rv_backend_pkg::SRA: begin
                // logical shift and refill of the vacated top bits with the sign
                r = a >> sh;
                if (a[`RV_XLEN-1])
                    r = r | ~({`RV_XLEN{1'b1}} >> sh);
            end
            rv_backend_pkg::SLT:  r = {{(`RV_XLEN-1){1'b0}}, signed_less(a, b)};
            rv_backend_pkg::SLTU: r = {{(`RV_XLEN-1){1'b0}}, a < b};
            default:              r = b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input rv_backend_pkg::br_op_e op,
            input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
        case (op)
            rv_backend_pkg::BEQ:  return a == b;
            rv_backend_pkg::BNE:  return a != b;
            rv_backend_pkg::BLT:  return signed_less(a, b);
            rv_backend_pkg::BGE:  return !signed_less(a, b);
            rv_backend_pkg::BLTU: return a < b;
            rv_backend_pkg::BGEU: return !(a < b);
            default:              return 1'b1;
        endcase
    endfunction

    function automatic logic [`RV_XLEN-1:0] load_ref(input rv_backend_pkg::lsu_op_e op,
                                                     input int a);
        logic [15:0] half;
        int w;
        w = a & ~3;
        half = {shadow[a + 1], shadow[a]};
        case (op)
            rv_backend_pkg::LB:  return {{(`RV_XLEN-8){shadow[a][7]}}, shadow[a]};
            rv_backend_pkg::LBU: return {{(`RV_XLEN-8){1'b0}}, shadow[a]};
            rv_backend_pkg::LH:  return {{(`RV_XLEN-16){half[15]}}, half};
            rv_backend_pkg::LHU: return {{(`RV_XLEN-16){1'b0}}, half};
            default:             return {shadow[w + 3], shadow[w + 2], shadow[w + 1], shadow[w]};
        endcase
    endfunction

    function automatic row_t blank_row(input string name);
        row_t r;
        r = '{default: '0, name: name, alu_op: rv_backend_pkg::ADD,
              br_op: rv_backend_pkg::BEQ, dest: rv_backend_pkg::DEST_ALU,
              lsu_op: rv_backend_pkg::LB};
        return r;
    endfunction

    // fills in the expected results and updates the RAM image
    task automatic add_row(input row_t r);
        logic [`RV_XLEN-1:0] res;
        logic [`RV_XLEN-1:0] target;
        logic [`RV_XLEN-1:0] actual;
        logic [`RV_XLEN-1:0] predicted;
        int a;
        int nbytes;
        res = alu_ref(r.alu_op, r.rs1, r.src_imm ? r.imm : r.rs2);
        a = int'(res) & (DMEM_BYTES - 1);
        if (r.br_op == rv_backend_pkg::JALR)
            target = (r.rs1 + r.imm) & ~`RV_XLEN'd1;
        else
            target = r.pc + r.imm;
        actual = (r.br_sig && branch_ref(r.br_op, r.rs1, r.rs2)) ? target : r.pc + 4;
        predicted = r.br_pred ? r.pred_pc : r.pc + 4;
        r.exp_redirect = !r.flush && r.br_sig && (actual != predicted);
        r.exp_redirect_pc = actual;
        r.exp_wb_valid = !r.flush && r.reg_wr && (r.rd != 0);
        case (r.dest)
            rv_backend_pkg::DEST_MEM: r.exp_wb_data = load_ref(r.lsu_op, a);
            rv_backend_pkg::DEST_PC4: r.exp_wb_data = r.pc + 4;
            default:                  r.exp_wb_data = res;
        endcase
        if (r.mem_wr && !r.flush) begin
            nbytes = (r.lsu_op == rv_backend_pkg::SB) ? 1 : (r.lsu_op == rv_backend_pkg::SH) ? 2 : 4;
            for (int i = 0; i < nbytes; i++)
                shadow[a + i] = r.rs2[8*i +: 8];
        end
        rows.push_back(r);
    endtask

    task automatic alu_row(input string name, input rv_backend_pkg::alu_op_e op,
            input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b,
            input logic use_imm, input logic [`RV_REG_AW-1:0] rd);
        row_t r;
        r = blank_row(name);
        r.alu_op = op;
        r.rs1 = a;
        r.rs2 = use_imm ? $random(seed) : b;
        r.imm = use_imm ? b : $random(seed);
        r.src_imm = use_imm;
        r.rd = rd;
        r.reg_wr = 1'b1;
        add_row(r);
    endtask

    task automatic mem_row(input string name, input rv_backend_pkg::lsu_op_e op,
            input logic [`RV_XLEN-1:0] addr, input logic [`RV_XLEN-1:0] data,
            input logic [`RV_REG_AW-1:0] rd, input logic fl);
        row_t r;
        r = blank_row(name);
        r.rs1 = addr & ~`RV_XLEN'd3;
        r.imm = addr & `RV_XLEN'd3;
        r.src_imm = 1'b1;
        r.rs2 = data;
        r.lsu_op = op;
        r.flush = fl;
        if (op inside {rv_backend_pkg::SB, rv_backend_pkg::SH, rv_backend_pkg::SW}) begin
            r.mem_wr = 1'b1;
        end else begin
            r.reg_wr = 1'b1;
            r.dest = rv_backend_pkg::DEST_MEM;
            r.rd = rd;
        end
        add_row(r);
    endtask

    task automatic branch_row(input string name, input rv_backend_pkg::br_op_e op,
            input logic [`RV_XLEN-1:0] pc, input logic [`RV_XLEN-1:0] a,
            input logic [`RV_XLEN-1:0] b, input logic [`RV_XLEN-1:0] imm,
            input logic pred, input logic [`RV_XLEN-1:0] pred_pc,
            input logic [`RV_REG_AW-1:0] rd, input logic fl);
        row_t r;
        r = blank_row(name);
        r.br_op = op;
        r.pc = pc;
        r.rs1 = a;
        r.rs2 = b;
        r.imm = imm;
        r.br_sig = 1'b1;
        r.br_pred = pred;
        r.pred_pc = pred_pc;
        r.flush = fl;
        if (op inside {rv_backend_pkg::JAL, rv_backend_pkg::JALR}) begin
            r.reg_wr = 1'b1;
            r.dest = rv_backend_pkg::DEST_PC4;
            r.rd = rd;
        end
        add_row(r);
    endtask

    task automatic drive_row(input row_t r);
        flush_i = r.flush;
        pc_i = r.pc;
        rs1_i = r.rs1;
        rs2_i = r.rs2;
        imm_i = r.imm;
        alu_op_i = r.alu_op;
        alu_src_imm_i = r.src_imm;
        br_sig_i = r.br_sig;
        br_op_i = r.br_op;
        br_pred_i = r.br_pred;
        new_pc_pred_i = r.pred_pc;
        data_dest_i = r.dest;
        lsu_op_i = r.lsu_op;
        reg_wr_addr_i = r.rd;
        reg_wr_sig_i = r.reg_wr;
        mem_wr_sig_i = r.mem_wr;
    endtask

    task automatic check_wb(input string name, input logic exp_valid,
            input logic [`RV_REG_AW-1:0] exp_addr, input logic [`RV_XLEN-1:0] exp_data);
        if (wb_valid_o !== exp_valid) begin
            $display("** Error: %s wb_valid expected %0b actual %0b", name, exp_valid, wb_valid_o);
            $display("TEST FAIL");
            $fatal(1, "writeback valid mismatch");
        end else if (exp_valid && (wb_addr_o !== exp_addr || wb_data_o !== exp_data)) begin
            $display("** Error: %s wb expected x%0d=%h actual x%0d=%h",
                     name, exp_addr, exp_data, wb_addr_o, wb_data_o);
            $display("TEST FAIL");
            $fatal(1, "writeback data mismatch");
        end
    endtask

    task automatic check_redirect(input string name, input logic exp_flag,
                                  input logic [`RV_XLEN-1:0] exp_pc);
        if (redirect_o !== exp_flag) begin
            $display("** Error: %s redirect expected %0b actual %0b", name, exp_flag, redirect_o);
            $display("TEST FAIL");
            $fatal(1, "redirect flag mismatch");
        end else if (exp_flag && redirect_pc_o !== exp_pc) begin
            $display("** Error: %s redirect_pc expected %h actual %h", name, exp_pc, redirect_pc_o);
            $display("TEST FAIL");
            $fatal(1, "redirect pc mismatch");
        end
    endtask

    initial begin
        rv_backend_pkg::alu_op_e op;
        int n;
        int wait_cnt;
        seed = 32'h5988;
        drive_row(blank_row("idle"));

        // random operands for every ALU op in register and immediate form
        for (int k = 0; k <= int'(rv_backend_pkg::PASS_B); k++) begin
            op = rv_backend_pkg::alu_op_e'(k);
            alu_row({op.name(), "_reg"}, op, $random(seed), $random(seed), 1'b0, 5'(k + 1));
            alu_row({op.name(), "_imm"}, op, $random(seed), $random(seed), 1'b1, 5'(k + 12));
        end
        alu_row("slt_min_vs_one", rv_backend_pkg::SLT, 32'h8000_0000, 32'd1, 1'b0, 5'd3);
        alu_row("slt_max_vs_min", rv_backend_pkg::SLT, 32'h7fff_ffff, 32'h8000_0000, 1'b0, 5'd4);
        alu_row("sltu_min_vs_one", rv_backend_pkg::SLTU, 32'h8000_0000, 32'd1, 1'b0, 5'd5);
        alu_row("slti_neg_imm", rv_backend_pkg::SLT, 32'd5, 32'hffff_ffff, 1'b1, 5'd6);
        alu_row("sltiu_neg_imm", rv_backend_pkg::SLTU, 32'd5, 32'hffff_ffff, 1'b1, 5'd7);
        alu_row("add_to_x0", rv_backend_pkg::ADD, 32'd1, 32'd2, 1'b0, 5'd0);

        mem_row("sw_word", rv_backend_pkg::SW, 32'h40, 32'h80ff_7f01, 5'd0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            mem_row($sformatf("lb_off%0d", k), rv_backend_pkg::LB, 32'h40 + k, 0, 5'(k + 1), 1'b0);
            mem_row($sformatf("lbu_off%0d", k), rv_backend_pkg::LBU, 32'h40 + k, 0, 5'(k + 5), 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            mem_row($sformatf("lh_off%0d", 2*k), rv_backend_pkg::LH, 32'h40 + 2*k, 0, 5'd9, 1'b0);
            mem_row($sformatf("lhu_off%0d", 2*k), rv_backend_pkg::LHU, 32'h40 + 2*k, 0, 5'd10, 1'b0);
        end
        mem_row("lw_word", rv_backend_pkg::LW, 32'h40, 0, 5'd11, 1'b0);
        mem_row("sh_low", rv_backend_pkg::SH, 32'h44, 32'h1234_8765, 5'd0, 1'b0);
        mem_row("sh_high", rv_backend_pkg::SH, 32'h46, 32'h0000_abcd, 5'd0, 1'b0);
        mem_row("lw_after_sh", rv_backend_pkg::LW, 32'h44, 0, 5'd12, 1'b0);
        mem_row("lh_high_neg", rv_backend_pkg::LH, 32'h46, 0, 5'd13, 1'b0);
        mem_row("lhu_low", rv_backend_pkg::LHU, 32'h44, 0, 5'd14, 1'b0);
        for (int k = 0; k < 4; k++)
            mem_row($sformatf("sb_off%0d", k), rv_backend_pkg::SB, 32'h48 + k,
                    32'hf433_9211 >> (8*k), 5'd0, 1'b0);
        mem_row("lw_after_sb", rv_backend_pkg::LW, 32'h48, 0, 5'd15, 1'b0);
        mem_row("lb_after_sb", rv_backend_pkg::LB, 32'h49, 0, 5'd16, 1'b0);
        mem_row("lbu_after_sb", rv_backend_pkg::LBU, 32'h4b, 0, 5'd17, 1'b0);

        branch_row("beq_mispred", rv_backend_pkg::BEQ, 32'h100, 7, 7, 32'h20, 0, 0, 0, 0);
        branch_row("beq_pred_ok", rv_backend_pkg::BEQ, 32'h104, 7, 7, 32'h20, 1, 32'h124, 0, 0);
        branch_row("bne_not_taken", rv_backend_pkg::BNE, 32'h108, 3, 3, 32'h40, 1, 32'h148, 0, 0);
        branch_row("blt_signed", rv_backend_pkg::BLT, 32'h10c, 32'hffff_ffff, 1, 32'hffff_fff0,
                   0, 0, 0, 0);
        branch_row("bltu_pred_ok", rv_backend_pkg::BLTU, 32'h110, 32'hffff_ffff, 1, 32'h10,
                   0, 0, 0, 0);
        branch_row("bge_wrong_target", rv_backend_pkg::BGE, 32'h114, 1, 32'hffff_ffff, 32'h30,
                   1, 32'h200, 0, 0);
        branch_row("bgeu_mispred", rv_backend_pkg::BGEU, 32'h118, 32'hffff_ffff, 1, 32'h8,
                   0, 0, 0, 0);
        branch_row("jal_unpredicted", rv_backend_pkg::JAL, 32'h200, 0, 0, 32'h40, 0, 0, 1, 0);
        branch_row("jal_predicted", rv_backend_pkg::JAL, 32'h204, 0, 0, 32'h40, 1, 32'h244, 2, 0);
        branch_row("jalr_odd_target", rv_backend_pkg::JALR, 32'h208, 32'h303, 0, 32'h4, 0, 0, 3, 0);
        branch_row("jalr_to_x0", rv_backend_pkg::JALR, 32'h20c, 32'h401, 0, 0, 0, 0, 0, 0);

        mem_row("sw_before_flush", rv_backend_pkg::SW, 32'h50, 32'hcafe_f00d, 5'd0, 1'b0);
        mem_row("sw_flushed", rv_backend_pkg::SW, 32'h50, 32'h1234_5678, 5'd0, 1'b1);
        branch_row("jal_flushed", rv_backend_pkg::JAL, 32'h300, 0, 0, 32'h80, 0, 0, 9, 1);
        mem_row("lw_after_flush", rv_backend_pkg::LW, 32'h50, 0, 5'd10, 1'b0);

        wait_cnt = 0;
        while (reset_n !== 1'b1) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("reset_n was never released");
                $display("TEST FAIL");
                $fatal(1, "reset timeout");
            end
        end
        #1;
        check_redirect("after_reset", 1'b0, '0);
        check_wb("after_reset", 1'b0, '0, '0);

        // redirect checked one cycle and writeback two cycles after issue
        n = rows.size();
        for (int k = 0; k < n + 2; k++) begin
            @(posedge clk);
            #1;
            if (k >= 1 && k <= n)
                check_redirect(rows[k-1].name, rows[k-1].exp_redirect, rows[k-1].exp_redirect_pc);
            if (k >= 2)
                check_wb(rows[k-2].name, rows[k-2].exp_wb_valid, rows[k-2].rd,
                         rows[k-2].exp_wb_data);
            if (k < n)
                drive_row(rows[k]);
            else
                drive_row(blank_row("bubble"));
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/rv_backend_pkg.sv
hw/ex_mem_if.sv
hw/execute_stage.sv
hw/ex_mem_register.sv
hw/memory_stage.sv
hw/rv_backend_top.sv
testbench/tb_rv_backend.sv

// ==== Bender.yml ====
package:
  name: rv_backend

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_backend_pkg.sv
      - hw/ex_mem_if.sv
      - hw/execute_stage.sv
      - hw/ex_mem_register.sv
      - hw/memory_stage.sv
      - hw/rv_backend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_rv_backend.sv
